// ==== csr_pkg.sv ====
package csr_pkg;

    // -------------------------------------------------------------------------
    // Machine-mode CSR addresses
    // -------------------------------------------------------------------------

    typedef enum logic [11:0] {
        CSR_SATP     = 12'h180,
        CSR_MSTATUS  = 12'h300,
        CSR_MIE      = 12'h304,
        CSR_MTVEC    = 12'h305,
        CSR_MSCRATCH = 12'h340,
        CSR_MEPC     = 12'h341,
        CSR_MCAUSE   = 12'h342,
        CSR_MTVAL    = 12'h343,
        CSR_MIP      = 12'h344,
        CSR_MCYCLE   = 12'hB00,
        CSR_MHARTID  = 12'hF14
    } csr_addr_e;

    // -------------------------------------------------------------------------
    // Write masks and mstatus fields
    // -------------------------------------------------------------------------

    // MIE, MPIE and the two MPP bits are the only mstatus fields implemented
    localparam logic [31:0] MSTATUS_MASK = 32'h0000_1888;

    // Direct mode only, so the mode field always reads zero
    localparam logic [31:0] MTVEC_MASK   = 32'hFFFF_FFFC;

    // Software, timer and external pending bits
    localparam logic [31:0] MIP_MASK     = 32'h0000_0888;

    localparam int MSTATUS_MIE    = 3;
    localparam int MSTATUS_MPIE   = 7;
    localparam int MSTATUS_MPP_LO = 11;

    // -------------------------------------------------------------------------
    // Architectural register bundle
    // -------------------------------------------------------------------------

    typedef struct packed {
        logic [31:0] mstatus;
        logic [31:0] mtvec;
        logic [31:0] mip;
        logic [31:0] mie;
        logic [31:0] mscratch;
        logic [31:0] mcause;
        logic [31:0] mtval;
        logic [31:0] mepc;
        logic [31:0] mcycle;
        logic [31:0] mhartid;
        logic [31:0] satp;
    } csr_pack;

endpackage

// ==== core_pkg.sv ====
package core_pkg;

    localparam int XLEN = 32;

    // Register forms first, then the immediate forms
    typedef enum logic [2:0] {
        CSR_RW,
        CSR_RS,
        CSR_RC,
        CSR_RWI,
        CSR_RSI,
        CSR_RCI
    } csr_op_e;

    typedef struct packed {
        logic            valid;
        csr_op_e         op;
        logic [11:0]     addr;
        logic [XLEN-1:0] rs1_data;
        logic [4:0]      zimm;
        logic            rs1_zero;
    } csr_req;

    typedef struct packed {
        logic            csr_write_enable;
        logic [11:0]     csr_dest_addr;
        logic [XLEN-1:0] csr_write_data;
    } csr_writer;

    typedef struct packed {
        logic            trap_valid;
        logic            mret_valid;
        logic [XLEN-1:0] cause;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] tval;
    } trap_req;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
    } redirect;

endpackage

// ==== csr.sv ====
`timescale 1ns/10ps

module csr (
    input  logic                clk,
    input  logic                rst,
    input  core_pkg::csr_writer writer,
    output csr_pkg::csr_pack    csrs
);

    csr_pkg::csr_pack csr_reg;
    logic             mcycle_hit;

    assign csrs = csr_reg;

    // A write to mcycle replaces the increment on that edge
    assign mcycle_hit = writer.csr_write_enable && (writer.csr_dest_addr == csr_pkg::CSR_MCYCLE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            csr_reg <= '0;
        end else begin
            if (!mcycle_hit) begin
                csr_reg.mcycle <= csr_reg.mcycle + 32'd1;
            end
            if (writer.csr_write_enable) begin
                case (writer.csr_dest_addr)
                    csr_pkg::CSR_MSTATUS:
                        csr_reg.mstatus <= writer.csr_write_data & csr_pkg::MSTATUS_MASK;
                    csr_pkg::CSR_MTVEC:
                        csr_reg.mtvec <= writer.csr_write_data & csr_pkg::MTVEC_MASK;
                    csr_pkg::CSR_MIP:
                        csr_reg.mip <= writer.csr_write_data & csr_pkg::MIP_MASK;
                    csr_pkg::CSR_MIE:      csr_reg.mie      <= writer.csr_write_data;
                    csr_pkg::CSR_MSCRATCH: csr_reg.mscratch <= writer.csr_write_data;
                    csr_pkg::CSR_MCAUSE:   csr_reg.mcause   <= writer.csr_write_data;
                    csr_pkg::CSR_MTVAL:    csr_reg.mtval    <= writer.csr_write_data;
                    csr_pkg::CSR_MEPC:     csr_reg.mepc     <= writer.csr_write_data;
                    csr_pkg::CSR_MCYCLE:   csr_reg.mcycle   <= writer.csr_write_data;
                    csr_pkg::CSR_MHARTID:  csr_reg.mhartid  <= writer.csr_write_data;
                    csr_pkg::CSR_SATP:     csr_reg.satp     <= writer.csr_write_data;
                    default: begin
                    end
                endcase
            end
        end
    end

    // Neither the executor nor the trap sequencer may emit a write to an unknown CSR
    assert property (@(posedge clk) disable iff (rst)
        writer.csr_write_enable |-> writer.csr_dest_addr inside {
            csr_pkg::CSR_MSTATUS, csr_pkg::CSR_MIE, csr_pkg::CSR_MTVEC,
            csr_pkg::CSR_MSCRATCH, csr_pkg::CSR_MEPC, csr_pkg::CSR_MCAUSE,
            csr_pkg::CSR_MTVAL, csr_pkg::CSR_MIP, csr_pkg::CSR_SATP,
            csr_pkg::CSR_MCYCLE, csr_pkg::CSR_MHARTID});

endmodule

// ==== csr_exec.sv ====
`timescale 1ns/10ps

module csr_exec (
    input  core_pkg::csr_req              req,
    input  csr_pkg::csr_pack              csrs,
    output logic [core_pkg::XLEN-1:0]     rd_data,
    output logic                          illegal,
    output core_pkg::csr_writer           exec_wr
);

    logic [core_pkg::XLEN-1:0] old_val;
    logic [core_pkg::XLEN-1:0] operand;
    logic [core_pkg::XLEN-1:0] new_val;
    logic                      known;
    logic                      imm_form;
    logic                      src_zero;
    logic                      read_only_op;

    // -------------------------------------------------------------------------
    // Read side
    // -------------------------------------------------------------------------

    always_comb begin
        known   = 1'b1;
        old_val = '0;
        case (req.addr)
            csr_pkg::CSR_MSTATUS:  old_val = csrs.mstatus;
            csr_pkg::CSR_MIE:      old_val = csrs.mie;
            csr_pkg::CSR_MTVEC:    old_val = csrs.mtvec;
            csr_pkg::CSR_MSCRATCH: old_val = csrs.mscratch;
            csr_pkg::CSR_MEPC:     old_val = csrs.mepc;
            csr_pkg::CSR_MCAUSE:   old_val = csrs.mcause;
            csr_pkg::CSR_MTVAL:    old_val = csrs.mtval;
            csr_pkg::CSR_MIP:      old_val = csrs.mip;
            csr_pkg::CSR_SATP:     old_val = csrs.satp;
            csr_pkg::CSR_MCYCLE:   old_val = csrs.mcycle;
            csr_pkg::CSR_MHARTID:  old_val = csrs.mhartid;
            default:               known   = 1'b0;
        endcase
    end

    assign rd_data = old_val;
    assign illegal = req.valid && !known;

    // -------------------------------------------------------------------------
    // Write side
    // -------------------------------------------------------------------------

    assign imm_form = req.op inside {core_pkg::CSR_RWI, core_pkg::CSR_RSI, core_pkg::CSR_RCI};

    assign operand  = imm_form ? {{(core_pkg::XLEN-5){1'b0}}, req.zimm} : req.rs1_data;
    assign src_zero = imm_form ? (req.zimm == 5'd0) : req.rs1_zero;

    always_comb begin
        case (req.op)
            core_pkg::CSR_RS,
            core_pkg::CSR_RSI: new_val = old_val | operand;
            core_pkg::CSR_RC,
            core_pkg::CSR_RCI: new_val = old_val & ~operand;
            default:           new_val = operand;
        endcase
    end

    // Set and clear with a zero source are pure reads and must not write
    assign read_only_op = src_zero && !(req.op inside {core_pkg::CSR_RW, core_pkg::CSR_RWI});

    assign exec_wr.csr_write_enable = req.valid && known && !read_only_op;
    assign exec_wr.csr_dest_addr    = req.addr;
    assign exec_wr.csr_write_data   = new_val;

endmodule

// ==== trap_seq.sv ====
`timescale 1ns/10ps

module trap_seq (
    input  logic                clk,
    input  logic                rst,
    input  core_pkg::trap_req   trap,
    input  core_pkg::csr_writer exec_wr,
    input  csr_pkg::csr_pack    csrs,
    output core_pkg::csr_writer writer,
    output logic                busy,
    output core_pkg::redirect   redir
);

    typedef enum logic [2:0] {
        IDLE,
        W_CAUSE,
        W_EPC,
        W_TVAL,
        W_STATUS,
        M_STATUS,
        REDIRECT
    } state_e;

    state_e                    state;
    state_e                    state_nxt;
    logic                      is_mret;
    logic [core_pkg::XLEN-1:0] cause_q;
    logic [core_pkg::XLEN-1:0] pc_q;
    logic [core_pkg::XLEN-1:0] tval_q;
    logic [31:0]               status_trap;
    logic [31:0]               status_mret;

    // -------------------------------------------------------------------------
    // Sequencing
    // -------------------------------------------------------------------------

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (trap.trap_valid) begin
                    state_nxt = W_CAUSE;
                end else if (trap.mret_valid) begin
                    state_nxt = M_STATUS;
                end
            end
            W_CAUSE:  state_nxt = W_EPC;
            W_EPC:    state_nxt = W_TVAL;
            W_TVAL:   state_nxt = W_STATUS;
            W_STATUS: state_nxt = REDIRECT;
            M_STATUS: state_nxt = REDIRECT;
            default:  state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            is_mret <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == IDLE && (trap.trap_valid || trap.mret_valid)) begin
                is_mret <= trap.mret_valid;
            end
        end
    end

    // Trap payload for the mcause, mepc and mtval writes
    always_ff @(posedge clk) begin
        if (state == IDLE && trap.trap_valid) begin
            cause_q <= trap.cause;
            pc_q    <= trap.pc;
            tval_q  <= trap.tval;
        end
    end

    // -------------------------------------------------------------------------
    // mstatus updates and write port
    // -------------------------------------------------------------------------

    always_comb begin
        status_trap = csrs.mstatus;
        status_trap[csr_pkg::MSTATUS_MPIE] = csrs.mstatus[csr_pkg::MSTATUS_MIE];
        status_trap[csr_pkg::MSTATUS_MIE] = 1'b0;
        status_trap[csr_pkg::MSTATUS_MPP_LO +: 2] = 2'b11;

        status_mret = csrs.mstatus;
        status_mret[csr_pkg::MSTATUS_MIE] = csrs.mstatus[csr_pkg::MSTATUS_MPIE];
        status_mret[csr_pkg::MSTATUS_MPIE] = 1'b1;
        status_mret[csr_pkg::MSTATUS_MPP_LO +: 2] = 2'b11;
    end

    always_comb begin
        writer.csr_write_enable = 1'b1;
        writer.csr_dest_addr    = csr_pkg::CSR_MSTATUS;
        writer.csr_write_data   = status_trap;
        case (state)
            IDLE: begin
                // A trap or mret in the same cycle wins over the instruction
                writer = exec_wr;
                if (trap.trap_valid || trap.mret_valid) begin
                    writer.csr_write_enable = 1'b0;
                end
            end
            W_CAUSE: begin
                writer.csr_dest_addr  = csr_pkg::CSR_MCAUSE;
                writer.csr_write_data = cause_q;
            end
            W_EPC: begin
                writer.csr_dest_addr  = csr_pkg::CSR_MEPC;
                writer.csr_write_data = pc_q;
            end
            W_TVAL: begin
                writer.csr_dest_addr  = csr_pkg::CSR_MTVAL;
                writer.csr_write_data = tval_q;
            end
            M_STATUS: writer.csr_write_data = status_mret;
            W_STATUS: writer.csr_write_data = status_trap;
            default:  writer.csr_write_enable = 1'b0;
        endcase
    end

    assign busy      = (state != IDLE);
    assign redir.valid = (state == REDIRECT);
    assign redir.pc    = is_mret ? csrs.mepc : csrs.mtvec;

    assert property (@(posedge clk) disable iff (rst)
        !(trap.trap_valid && trap.mret_valid));

    // A redirect sees the mstatus that its own sequence left in the register file
    assert property (@(posedge clk) disable iff (rst)
        redir.valid |-> csrs.mstatus[csr_pkg::MSTATUS_MPP_LO +: 2] == 2'b11 &&
            (is_mret ? csrs.mstatus[csr_pkg::MSTATUS_MPIE]
                     : !csrs.mstatus[csr_pkg::MSTATUS_MIE]));

endmodule

// ==== csr_unit.sv ====
`timescale 1ns/10ps

module csr_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  core_pkg::csr_req              req,
    input  core_pkg::trap_req             trap,
    output logic [core_pkg::XLEN-1:0]     rd_data,
    output logic                          illegal,
    output logic                          busy,
    output core_pkg::redirect             redir,
    output csr_pkg::csr_pack              csrs
);

    core_pkg::csr_writer exec_wr;
    core_pkg::csr_writer writer;

    csr_exec u_exec (
        .req     (req),
        .csrs    (csrs),
        .rd_data (rd_data),
        .illegal (illegal),
        .exec_wr (exec_wr)
    );

    // Sole owner of the register file write port
    trap_seq u_seq (
        .clk     (clk),
        .rst     (rst),
        .trap    (trap),
        .exec_wr (exec_wr),
        .csrs    (csrs),
        .writer  (writer),
        .busy    (busy),
        .redir   (redir)
    );

    csr u_csr (
        .clk    (clk),
        .rst    (rst),
        .writer (writer),
        .csrs   (csrs)
    );

endmodule

// ==== tb_csr_model.svh ====
`ifndef TB_CSR_MODEL_SVH
`define TB_CSR_MODEL_SVH

// Shadow registers kept in csr_pack field order, mstatus first
logic [11:0] addr_tab [11] = '{12'h300, 12'h305, 12'h344, 12'h304, 12'h340, 12'h342,
                               12'h343, 12'h341, 12'hB00, 12'hF14, 12'h180};
string       reg_names [11] = '{"mstatus", "mtvec", "mip", "mie", "mscratch", "mcause",
                                "mtval", "mepc", "mcycle", "mhartid", "satp"};
logic [31:0] shadow [11];
logic        pend_en;
int          pend_idx;
logic [31:0] pend_data;
int          seq_kind;
int          seq_step;
logic [31:0] saved [3];

function automatic int reg_index(logic [11:0] a);
    foreach (addr_tab[i]) begin
        if (addr_tab[i] == a) begin
            return i;
        end
    end
    return -1;
endfunction

function automatic logic [31:0] write_mask(int idx);
    case (idx)
        0:       return 32'h0000_1888;
        1:       return 32'hFFFF_FFFC;
        2:       return 32'h0000_0888;
        default: return 32'hFFFF_FFFF;
    endcase
endfunction

function automatic void model_reset();
    foreach (shadow[i]) begin
        shadow[i] = '0;
    end
    pend_en  = 1'b0;
    seq_kind = 0;
    seq_step = 0;
endfunction

// Expected outputs of the current cycle and the write that lands on the next edge
task automatic model_cycle(input core_pkg::csr_req r, input core_pkg::trap_req t,
                           output logic exp_busy, output logic exp_rv,
                           output logic [31:0] exp_pc, output logic exp_ill,
                           output logic [31:0] exp_rd);
    int          idx;
    int          op_n;
    logic [31:0] opnd;
    logic [31:0] st;
    idx      = reg_index(r.addr);
    op_n     = int'(r.op);
    pend_en  = 1'b0;
    exp_busy = (seq_step != 0);
    exp_rv   = 1'b0;
    exp_pc   = '0;
    exp_ill  = r.valid && (idx < 0);
    exp_rd   = (idx < 0) ? 32'd0 : shadow[idx];
    st       = shadow[0];
    if (seq_kind == 1 && seq_step >= 1 && seq_step <= 4) begin
        // Trap entry stores mcause, mepc, mtval and then mstatus
        pend_en  = 1'b1;
        pend_idx = (seq_step == 1) ? 5 : (seq_step == 2) ? 7 : (seq_step == 3) ? 6 : 0;
        if (seq_step == 4) begin
            st[7]     = shadow[0][3];
            st[3]     = 1'b0;
            st[12:11] = 2'b11;
            pend_data = st;
        end else begin
            pend_data = saved[seq_step-1];
        end
        seq_step++;
    end else if (seq_kind == 2 && seq_step == 1) begin
        st[3]     = shadow[0][7];
        st[7]     = 1'b1;
        st[12:11] = 2'b11;
        pend_en   = 1'b1;
        pend_idx  = 0;
        pend_data = st;
        seq_step++;
    end else if (seq_step != 0) begin
        exp_rv   = 1'b1;
        exp_pc   = (seq_kind == 1) ? shadow[1] : shadow[7];
        seq_step = 0;
    end else if (t.trap_valid) begin
        seq_kind = 1;
        seq_step = 1;
        saved[0] = t.cause;
        saved[1] = t.pc;
        saved[2] = t.tval;
    end else if (t.mret_valid) begin
        seq_kind = 2;
        seq_step = 1;
    end else if (r.valid && idx >= 0) begin
        opnd     = (op_n >= 3) ? {27'd0, r.zimm} : r.rs1_data;
        pend_idx = idx;
        case (op_n % 3)
            1:       pend_data = shadow[idx] | opnd;
            2:       pend_data = shadow[idx] & ~opnd;
            default: pend_data = opnd;
        endcase
        // Set and clear from x0 or a zero immediate are pure reads
        pend_en = (op_n % 3 == 0) || ((op_n >= 3) ? (r.zimm != 5'd0) : !r.rs1_zero);
    end
endtask

function automatic void model_edge();
    if (!(pend_en && pend_idx == 8)) begin
        shadow[8] = shadow[8] + 32'd1;
    end
    if (pend_en) begin
        shadow[pend_idx] = pend_data & write_mask(pend_idx);
    end
    pend_en = 1'b0;
endfunction

`endif

// ==== tb_csr_unit.sv ====
`timescale 1ns/10ps

module tb_csr_unit;

    localparam int NUM_OPS     = 400;
    localparam int CYCLE_LIMIT = NUM_OPS * 6 + 100;

    logic                      clk;
    logic                      rst;
    core_pkg::csr_req          req;
    core_pkg::trap_req         trap;
    logic [core_pkg::XLEN-1:0] rd_data;
    logic                      illegal;
    logic                      busy;
    core_pkg::redirect         redir;
    csr_pkg::csr_pack          csrs;

    int                        errors = 0;
    int                        checks = 0;
    int                        cycles = 0;
    logic                      dut_busy;
    string                     test_name;
    core_pkg::csr_req          idle_req;
    core_pkg::trap_req         idle_trap;

    `include "tb_csr_model.svh"

    csr_unit DUT (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .trap    (trap),
        .rd_data (rd_data),
        .illegal (illegal),
        .busy    (busy),
        .redir   (redir),
        .csrs    (csrs)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: operations did not finish");
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s %s: expected %h, actual %h", test_name, name, exp, act);
        end
    endtask

    task automatic compare_regs();
        logic [351:0] flat;
        flat = csrs;
        foreach (reg_names[i]) begin
            check_value(reg_names[i], shadow[i], flat[351-32*i -: 32]);
        end
    endtask

    // ------------------------------------------------------------------------
    // Each call drives one cycle and checks it against the model
    // ------------------------------------------------------------------------

    task automatic run_cycle(core_pkg::csr_req r, core_pkg::trap_req t);
        logic        exp_busy;
        logic        exp_rv;
        logic        exp_ill;
        logic [31:0] exp_pc;
        logic [31:0] exp_rd;
        #1;
        req  = r;
        trap = t;
        #18;
        model_cycle(r, t, exp_busy, exp_rv, exp_pc, exp_ill, exp_rd);
        compare_regs();
        check_value("busy", exp_busy, busy);
        check_value("redir.valid", exp_rv, redir.valid);
        if (exp_rv) begin
            check_value("redir.pc", exp_pc, redir.pc);
        end
        check_value("illegal", exp_ill, illegal);
        if (r.valid) begin
            check_value("rd_data", exp_rd, rd_data);
        end
        @(posedge clk);
        model_edge();
        #1;
        dut_busy = busy;
    endtask

    task automatic apply_reset();
        test_name = "reset";
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        #1;
        model_reset();
        compare_regs();
        check_value("busy", 1'b0, busy);
        check_value("redir.valid", 1'b0, redir.valid);
        check_value("illegal", 1'b0, illegal);
        @(posedge clk);
        model_edge();
        #1;
        dut_busy = busy;
    endtask

    task automatic random_instr(output core_pkg::csr_req r, input logic legal);
        logic [11:0] a;
        r       = '0;
        r.valid = 1'b1;
        r.op    = core_pkg::csr_op_e'($urandom_range(0, 5));
        if (legal) begin
            a = addr_tab[$urandom_range(0, 10)];
        end else begin
            do begin
                a = 12'($urandom);
            end while (reg_index(a) >= 0);
        end
        r.addr     = a;
        r.rs1_zero = ($urandom_range(0, 3) == 0);
        r.rs1_data = r.rs1_zero ? 32'd0 : $urandom;
        r.zimm     = ($urandom_range(0, 3) == 0) ? 5'd0 : 5'($urandom);
    endtask

    initial begin
        int                n;
        int                kind;
        core_pkg::csr_req  r;
        core_pkg::trap_req t;
        void'($urandom(50866));
        clk       = 1'b0;
        rst       = 1'b1;
        req       = '0;
        trap      = '0;
        idle_req  = '0;
        idle_trap = '0;
        apply_reset();
        for (n = 0; n < NUM_OPS; n++) begin
            t    = '0;
            r    = '0;
            kind = $urandom_range(0, 9);
            if (kind < 5) begin
                test_name = $sformatf("op%0d instr", n);
                random_instr(r, 1'b1);
            end else if (kind == 5) begin
                test_name = $sformatf("op%0d illegal", n);
                random_instr(r, 1'b0);
            end else if (kind == 6) begin
                test_name = $sformatf("op%0d idle", n);
            end else if (kind < 9) begin
                test_name    = $sformatf("op%0d trap", n);
                t.trap_valid = 1'b1;
                t.cause      = $urandom;
                t.pc         = $urandom;
                t.tval       = $urandom;
                // An instruction in the trap cycle must be dropped
                if ($urandom_range(0, 1) == 1) begin
                    random_instr(r, 1'b1);
                end
            end else begin
                test_name    = $sformatf("op%0d mret", n);
                t.mret_valid = 1'b1;
            end
            run_cycle(r, t);
            while (dut_busy) begin
                run_cycle(idle_req, idle_trap);
            end
        end
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+.
csr_pkg.sv
core_pkg.sv
csr.sv
csr_exec.sv
trap_seq.sv
csr_unit.sv
tb_csr_unit.sv

// ==== Bender.yml ====
package:
  name: csr_unit

sources:
  - csr_pkg.sv
  - core_pkg.sv
  - csr.sv
  - csr_exec.sv
  - trap_seq.sv
  - csr_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_csr_unit.sv
